// File: Makefile
TOP = tb_duel

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f duel_top.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -f duel_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: duel_top.f
hdl/keypad_pkg.sv
hdl/game_pkg.sv
hdl/tick_gen.sv
hdl/keypad_scan.sv
hdl/soldier_motion.sv
hdl/projectile_engine.sv
hdl/score_keeper.sv
hdl/duel_top.sv
verif/tb_clock.sv
verif/tb_duel.sv

// File: hdl/duel_top.sv
`timescale 1ns/1ps

module duel_top #(
    parameter int SAMPLE_DIV = game_pkg::SAMPLE_DIV_DEF,
    parameter int GAME_DIV   = game_pkg::GAME_DIV_DEF
) (
    input  logic                    CLK,
    input  logic                    RST,
    input  keypad_pkg::key_nibble_t cols_a,
    input  keypad_pkg::key_nibble_t cols_b,
    input  logic [1:0]              sw,
    output keypad_pkg::key_nibble_t rows_a,
    output keypad_pkg::key_nibble_t rows_b,
    output game_pkg::coord_t        soldier_a_y,
    output game_pkg::coord_t        soldier_b_y,
    output game_pkg::shot_t         shot_a,
    output game_pkg::shot_t         shot_b,
    output game_pkg::bcd_score_t    score_a,
    output game_pkg::bcd_score_t    score_b
);

    import keypad_pkg::*;
    import game_pkg::*;

    logic        sample_tick;  // Keypad sample strobe
    logic        game_tick;    // Game step strobe
    player_cmd_t cmd_a;
    player_cmd_t cmd_b;
    speed_t      speed;
    logic [1:0]  points_a;
    logic [1:0]  points_b;

    tick_gen #(
        .SAMPLE_DIV(SAMPLE_DIV),
        .GAME_DIV  (GAME_DIV)
    ) i_tick_gen (
        .CLK(CLK), .RST(RST), .sample_tick(sample_tick), .game_tick(game_tick)
    );

    // One scanner per keypad
    keypad_scan i_keypad_a (
        .CLK(CLK), .RST(RST), .sample_tick(sample_tick),
        .cols(cols_a), .rows(rows_a), .cmd(cmd_a)
    );

    keypad_scan i_keypad_b (
        .CLK(CLK), .RST(RST), .sample_tick(sample_tick),
        .cols(cols_b), .rows(rows_b), .cmd(cmd_b)
    );

    soldier_motion i_soldier_motion (
        .CLK(CLK), .RST(RST), .game_tick(game_tick), .sw(sw),
        .cmd_a(cmd_a), .cmd_b(cmd_b),
        .soldier_a_y(soldier_a_y), .soldier_b_y(soldier_b_y), .speed(speed)
    );

    projectile_engine i_projectile_engine (
        .CLK(CLK), .RST(RST), .game_tick(game_tick),
        .fire_a(cmd_a.fire), .fire_b(cmd_b.fire), .speed(speed),
        .soldier_a_y(soldier_a_y), .soldier_b_y(soldier_b_y),
        .shot_a(shot_a), .shot_b(shot_b), .points_a(points_a), .points_b(points_b)
    );

    score_keeper i_score_keeper (
        .CLK(CLK), .RST(RST), .points_a(points_a), .points_b(points_b),
        .score_a(score_a), .score_b(score_b)
    );

endmodule

// File: hdl/game_pkg.sv
package game_pkg;

    typedef logic [10:0] coord_t;      // Screen coordinate in pixels
    typedef logic [2:0]  speed_t;      // Shot step per game tick, 1 to 4
    typedef logic [3:0]  bcd_digit_t;  // One decimal digit

    // ------------------------------
    // Playfield geometry
    // ------------------------------
    localparam coord_t Y_MIN     = 11'd90;   // Top soldier limit
    localparam coord_t Y_MAX     = 11'd410;  // Bottom soldier limit
    localparam coord_t Y_RESET_A = 11'd100;
    localparam coord_t Y_RESET_B = 11'd300;

    localparam coord_t X_SOLDIER_A = 11'd20;   // Left player
    localparam coord_t X_SOLDIER_B = 11'd590;  // Right player
    localparam coord_t X_SHOT_A    = 11'd20;   // Launch column of shot A
    localparam coord_t X_SHOT_B    = 11'd600;  // Launch column of shot B
    localparam coord_t X_WALL_B    = 11'd610;  // Shot A scores here
    localparam coord_t X_MID       = 11'd320;  // Decides who wins a shot clash

    // Collision boxes
    localparam coord_t SHOT_W    = 11'd32;
    localparam coord_t SHOT_H    = 11'd16;
    localparam coord_t SOLDIER_W = 11'd40;
    localparam coord_t SOLDIER_H = 11'd24;

    typedef enum logic {
        SHOT_IDLE,
        SHOT_FLYING
    } shot_phase_t;

    typedef struct packed {
        shot_phase_t phase;
        coord_t      x;  // Left edge
        coord_t      y;  // Top edge
    } shot_t;

    typedef struct packed {
        bcd_digit_t hundreds;
        bcd_digit_t tens;
        bcd_digit_t units;
    } bcd_score_t;

    // Divider defaults for the board clock
    localparam int SAMPLE_DIV_DEF = 10000;   // Keypad sample rate
    localparam int GAME_DIV_DEF   = 900000;  // Game step rate

endpackage

// File: hdl/keypad_pkg.sv
package keypad_pkg;

    typedef logic [3:0] key_nibble_t;  // Row drive or column sense
    typedef logic [7:0] key_code_t;    // One-hot row over one-hot column

    // Game keys all sit on row 1
    localparam key_code_t KEY_UP   = 8'b0010_0001;  // Row 1 column 0
    localparam key_code_t KEY_DOWN = 8'b0010_0010;  // Row 1 column 1
    localparam key_code_t KEY_FIRE = 8'b0010_1000;  // Row 1 column 3

    localparam int DEBOUNCE_LEN = 8;   // High samples before a column counts
    localparam int ROW_DWELL    = 12;  // Sample strobes per driven row

    // Commands of one player
    typedef struct packed {
        logic up;    // Level while key held
        logic down;  // Level while key held
        logic fire;  // One-cycle pulse on press
    } player_cmd_t;

endpackage

// File: hdl/keypad_scan.sv
`timescale 1ns/1ps

module keypad_scan (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    sample_tick,
    input  keypad_pkg::key_nibble_t cols,
    output keypad_pkg::key_nibble_t rows,
    output keypad_pkg::player_cmd_t cmd
);

    import keypad_pkg::*;

    localparam int DWELL_W  = $clog2(ROW_DWELL);
    localparam int SCAN_LEN = 4 * ROW_DWELL;  // Strobes in one full scan
    localparam int IDLE_W   = $clog2(SCAN_LEN + 1);

    logic [DWELL_W-1:0]           dwell_cnt;   // Strobes spent on current row
    logic [3:0][DEBOUNCE_LEN-1:0] col_hist;    // Sample history per column
    key_nibble_t                  col_stable;  // Column held for the whole history
    key_code_t                    scan_code;
    logic                         pressed;
    logic                         pressed_q;
    logic                         new_press;
    key_code_t                    held_code;   // Last captured key
    logic [IDLE_W-1:0]            idle_cnt;    // Strobes without a press
    logic                         fire_q;

    // ------------------------------
    // Row ring
    // ------------------------------
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            dwell_cnt <= '0;
            rows      <= 4'b0001;  // Row 0 first
        end else if (sample_tick) begin
            if (dwell_cnt == DWELL_W'(ROW_DWELL - 1)) begin
                dwell_cnt <= '0;
                rows      <= {rows[2:0], rows[3]};  // Next row
            end else begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end
        end
    end

    // ------------------------------
    // Column debounce
    // ------------------------------
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            col_hist <= '0;
        end else if (sample_tick) begin
            for (int c = 0; c < 4; c++) begin
                col_hist[c] <= {col_hist[c][DEBOUNCE_LEN-2:0], cols[c]};
            end
        end
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            col_stable[c] = &col_hist[c];  // All samples high
        end
    end

    assign pressed   = |col_stable;
    assign new_press = pressed && !pressed_q;  // Rising edge only
    assign scan_code = {rows, col_stable};

    // Capture and release timeout
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            pressed_q <= 1'b0;
            held_code <= '0;
            idle_cnt  <= '0;
            fire_q    <= 1'b0;
        end else begin
            pressed_q <= pressed;
            fire_q    <= new_press && (scan_code == KEY_FIRE);
            if (new_press) begin
                held_code <= scan_code;
            end else if (idle_cnt == IDLE_W'(SCAN_LEN)) begin
                held_code <= '0;  // Whole scan with nothing pressed
            end
            if (pressed) begin
                idle_cnt <= '0;
            end else if (sample_tick && idle_cnt != IDLE_W'(SCAN_LEN)) begin
                idle_cnt <= idle_cnt + 1'b1;  // Saturates at one scan
            end
        end
    end

    // Decode to player commands
    always_comb begin
        cmd.up   = (held_code == KEY_UP);
        cmd.down = (held_code == KEY_DOWN);
        cmd.fire = fire_q;
    end

    a_rows_onehot: assert property (@(posedge CLK) disable iff (RST) $onehot(rows));

endmodule

// File: hdl/projectile_engine.sv
`timescale 1ns/1ps

module projectile_engine (
    input  logic             CLK,
    input  logic             RST,
    input  logic             game_tick,
    input  logic             fire_a,
    input  logic             fire_b,
    input  game_pkg::speed_t speed,
    input  game_pkg::coord_t soldier_a_y,
    input  game_pkg::coord_t soldier_b_y,
    output game_pkg::shot_t  shot_a,
    output game_pkg::shot_t  shot_b,
    output logic [1:0]       points_a,
    output logic [1:0]       points_b
);

    import game_pkg::*;

    logic pend_a;     // Fire seen while idle, launch on next tick
    logic pend_b;
    logic fly_a;
    logic fly_b;
    logic meet;       // Both shots overlap
    logic blocked_a;  // Shot A inside soldier B box
    logic blocked_b;  // Shot B inside soldier A box
    logic wall_a;     // Shot A at the right wall
    logic wall_b;     // Shot B at the left wall

    // Axis-aligned box test
    function automatic logic overlap(coord_t ax, coord_t ay, coord_t aw, coord_t ah,
                                     coord_t bx, coord_t by, coord_t bw, coord_t bh);
        return (ax < bx + bw) && (ax + aw > bx) && (ay < by + bh) && (ay + ah > by);
    endfunction

    // ------------------------------
    // Event detection
    // ------------------------------
    always_comb begin
        fly_a     = (shot_a.phase == SHOT_FLYING);
        fly_b     = (shot_b.phase == SHOT_FLYING);
        meet      = fly_a && fly_b &&
                    overlap(shot_a.x, shot_a.y, SHOT_W, SHOT_H,
                            shot_b.x, shot_b.y, SHOT_W, SHOT_H);
        blocked_a = fly_a && overlap(shot_a.x, shot_a.y, SHOT_W, SHOT_H,
                                     X_SOLDIER_B, soldier_b_y, SOLDIER_W, SOLDIER_H);
        blocked_b = fly_b && overlap(shot_b.x, shot_b.y, SHOT_W, SHOT_H,
                                     X_SOLDIER_A, soldier_a_y, SOLDIER_W, SOLDIER_H);
        wall_a    = fly_a && (shot_a.x >= X_WALL_B);
        wall_b    = fly_b && (shot_b.x < coord_t'(speed));  // Next step would pass 0

        // Points land on the same tick that ends the shot
        points_a = 2'd0;
        points_b = 2'd0;
        if (game_tick) begin
            if (meet) begin
                if (shot_a.x >= X_MID) begin
                    points_a = 2'd1;  // Clash on B's half
                end else begin
                    points_b = 2'd1;
                end
            end else begin
                if (wall_a && !blocked_a) begin
                    points_a = 2'd2;
                end
                if (wall_b && !blocked_b) begin
                    points_b = 2'd2;
                end
            end
        end
    end

    // ------------------------------
    // Shot state
    // ------------------------------
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            shot_a <= '{phase: SHOT_IDLE, x: X_SHOT_A, y: Y_RESET_A};
            shot_b <= '{phase: SHOT_IDLE, x: X_SHOT_B, y: Y_RESET_B};
            pend_a <= 1'b0;
            pend_b <= 1'b0;
        end else begin
            // Shot A flies right
            if (!fly_a) begin
                if (game_tick && pend_a) begin
                    shot_a <= '{phase: SHOT_FLYING, x: X_SHOT_A, y: soldier_a_y};
                    pend_a <= 1'b0;
                end else if (fire_a) begin
                    pend_a <= 1'b1;
                end
            end else if (game_tick) begin
                if (meet || blocked_a || wall_a) begin
                    shot_a.phase <= SHOT_IDLE;  // Last position kept
                end else begin
                    shot_a.x <= shot_a.x + coord_t'(speed);
                end
            end

            // Shot B flies left
            if (!fly_b) begin
                if (game_tick && pend_b) begin
                    shot_b <= '{phase: SHOT_FLYING, x: X_SHOT_B, y: soldier_b_y};
                    pend_b <= 1'b0;
                end else if (fire_b) begin
                    pend_b <= 1'b1;
                end
            end else if (game_tick) begin
                if (meet || blocked_b || wall_b) begin
                    shot_b.phase <= SHOT_IDLE;
                end else begin
                    shot_b.x <= shot_b.x - coord_t'(speed);
                end
            end
        end
    end

    // A point ends a flying shot on a game tick
    a_points_a_end: assert property (@(posedge CLK) disable iff (RST)
        (points_a != 2'd0) |-> (game_tick && fly_a) ##1 (shot_a.phase == SHOT_IDLE));
    a_points_b_end: assert property (@(posedge CLK) disable iff (RST)
        (points_b != 2'd0) |-> (game_tick && fly_b) ##1 (shot_b.phase == SHOT_IDLE));

endmodule

// File: hdl/score_keeper.sv
`timescale 1ns/1ps

module score_keeper (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic [1:0]           points_a,
    input  logic [1:0]           points_b,
    output game_pkg::bcd_score_t score_a,
    output game_pkg::bcd_score_t score_b
);

    import game_pkg::*;

    // Adds 0..3 with carry and wraps past 999
    function automatic bcd_score_t bcd_add(bcd_score_t s, logic [1:0] pts);
        bcd_score_t r;
        logic [4:0] u;
        logic       carry;
        r       = s;
        u       = 5'(s.units) + 5'(pts);
        carry   = (u >= 5'd10);
        r.units = carry ? bcd_digit_t'(u - 5'd10) : bcd_digit_t'(u);
        if (carry) begin
            if (s.tens == 4'd9) begin
                r.tens     = 4'd0;
                r.hundreds = (s.hundreds == 4'd9) ? 4'd0 : s.hundreds + 4'd1;  // Mod 1000
            end else begin
                r.tens = s.tens + 4'd1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            score_a <= '0;  // 000
            score_b <= '0;
        end else begin
            score_a <= bcd_add(score_a, points_a);  // Zero points leaves it unchanged
            score_b <= bcd_add(score_b, points_b);
        end
    end

    a_bcd_digits: assert property (@(posedge CLK) disable iff (RST)
        score_a.hundreds <= 4'd9 && score_a.tens <= 4'd9 && score_a.units <= 4'd9 &&
        score_b.hundreds <= 4'd9 && score_b.tens <= 4'd9 && score_b.units <= 4'd9);

endmodule

// File: hdl/soldier_motion.sv
`timescale 1ns/1ps

module soldier_motion (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    game_tick,
    input  logic [1:0]              sw,
    input  keypad_pkg::player_cmd_t cmd_a,
    input  keypad_pkg::player_cmd_t cmd_b,
    output game_pkg::coord_t        soldier_a_y,
    output game_pkg::coord_t        soldier_b_y,
    output game_pkg::speed_t        speed
);

    import keypad_pkg::*;
    import game_pkg::*;

    // One pixel per step, up wins over down
    function automatic coord_t step_y(coord_t y, player_cmd_t c);
        coord_t ny;
        ny = y;
        if (c.up && y > Y_MIN) begin
            ny = y - 1'b1;  // Screen y grows downward
        end else if (c.down && y < Y_MAX) begin
            ny = y + 1'b1;
        end
        return ny;
    endfunction

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            soldier_a_y <= Y_RESET_A;
            soldier_b_y <= Y_RESET_B;
            speed       <= 3'd1;  // Slowest shot
        end else if (game_tick) begin
            speed       <= speed_t'(sw) + 1'b1;  // Switches 0..3 give 1..4
            soldier_a_y <= step_y(soldier_a_y, cmd_a);
            soldier_b_y <= step_y(soldier_b_y, cmd_b);
        end
    end

    // Both soldiers stay on the field
    a_y_in_range: assert property (@(posedge CLK) disable iff (RST)
        soldier_a_y >= Y_MIN && soldier_a_y <= Y_MAX &&
        soldier_b_y >= Y_MIN && soldier_b_y <= Y_MAX);

endmodule

// File: hdl/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
    parameter int SAMPLE_DIV = game_pkg::SAMPLE_DIV_DEF,  // CLK cycles per keypad sample
    parameter int GAME_DIV   = game_pkg::GAME_DIV_DEF     // CLK cycles per game step
) (
    input  logic CLK,
    input  logic RST,
    output logic sample_tick,
    output logic game_tick
);

    localparam int SAMPLE_W = $clog2(SAMPLE_DIV + 1);
    localparam int GAME_W   = $clog2(GAME_DIV + 1);

    logic [SAMPLE_W-1:0] sample_cnt;  // Free running
    logic [GAME_W-1:0]   game_cnt;    // Free running

    // Strobes at terminal count, acted on by the following edge
    assign sample_tick = (sample_cnt == SAMPLE_W'(SAMPLE_DIV - 1));
    assign game_tick   = (game_cnt == GAME_W'(GAME_DIV - 1));

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            sample_cnt <= '0;
            game_cnt   <= '0;
        end else begin
            sample_cnt <= sample_tick ? '0 : sample_cnt + 1'b1;  // Wrap on strobe
            game_cnt   <= game_tick ? '0 : game_cnt + 1'b1;
        end
    end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 8,  // ns
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic RST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        RST = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;  // Released between edges
    end

endmodule

// File: verif/tb_duel.sv
`timescale 1ns/1ps

module tb_duel;

    import keypad_pkg::*;
    import game_pkg::*;

    localparam int SAMPLE_DIV   = 4;
    localparam int GAME_DIV     = 400;
    localparam int CLK_PERIOD   = 8;
    localparam int SCAN_CYC     = 4 * ROW_DWELL * SAMPLE_DIV;  // CLK cycles per keypad scan
    localparam int TICKS_NEEDED = 1300;  // Motion, two flights at speed 1, approach
    localparam int FLIGHT_LIMIT = 700 * GAME_DIV;
    localparam logic [1:0] MOVE_NONE = 2'd0;
    localparam logic [1:0] MOVE_UP   = 2'd1;
    localparam logic [1:0] MOVE_DOWN = 2'd2;

    logic        CLK, RST;
    key_nibble_t cols_a, cols_b, rows_a, rows_b;
    logic [1:0]  sw;
    coord_t      soldier_a_y, soldier_b_y, prev_ya, prev_yb;
    shot_t       shot_a, shot_b, prev_a, prev_b;
    bcd_score_t  score_a, score_b;
    key_code_t   held_key [2];  // Key pressed on each pad, 0 for none
    logic [1:0]  mode [2];      // Direction the held key asks for
    logic        steady [2];    // Key captured, motion must be exact
    logic        quiet [2];     // Released for over a scan
    int          tick_cnt, model_a, model_b, mismatch_cnt, fail_cnt;
    logic        tick, prev_tick, end_a, end_b;
    speed_t      exp_speed, prev_speed;
    integer      seed;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) i_tb_clock (.CLK(CLK), .RST(RST));

    duel_top #(.SAMPLE_DIV(SAMPLE_DIV), .GAME_DIV(GAME_DIV)) i_duel_top (
        .CLK(CLK), .RST(RST), .cols_a(cols_a), .cols_b(cols_b), .sw(sw),
        .rows_a(rows_a), .rows_b(rows_b), .soldier_a_y(soldier_a_y), .soldier_b_y(soldier_b_y),
        .shot_a(shot_a), .shot_b(shot_b), .score_a(score_a), .score_b(score_b)
    );

    // Keypad model, column high only while the key's row is driven
    assign cols_a = ((held_key[0][7:4] & rows_a) != 4'b0) ? held_key[0][3:0] : 4'b0;
    assign cols_b = ((held_key[1][7:4] & rows_b) != 4'b0) ? held_key[1][3:0] : 4'b0;

    // ------------------------------
    // Reference model
    // ------------------------------
    assign tick  = (tick_cnt == GAME_DIV - 1);  // First one GAME_DIV cycles after reset
    assign end_a = prev_tick && prev_a.phase == SHOT_FLYING && shot_a.phase == SHOT_IDLE;
    assign end_b = prev_tick && prev_b.phase == SHOT_FLYING && shot_b.phase == SHOT_IDLE;

    function automatic logic shots_touch(shot_t a, shot_t b);
        coord_t dx, dy;
        dx = (a.x > b.x) ? a.x - b.x : b.x - a.x;
        dy = (a.y > b.y) ? a.y - b.y : b.y - a.y;
        return dx < SHOT_W && dy < SHOT_H;  // Equal boxes
    endfunction

    // Shot box against a soldier box
    function automatic logic hits_soldier(shot_t s, coord_t sx, coord_t sy);
        return s.x < sx + SOLDIER_W && sx < s.x + SHOT_W &&
               s.y < sy + SOLDIER_H && sy < s.y + SHOT_H;
    endfunction

    function automatic int score_val(bcd_score_t s);
        return int'(s.hundreds) * 100 + int'(s.tens) * 10 + int'(s.units);
    endfunction

    // Soldier step rules seen from one edge to the next
    function automatic logic motion_ok(coord_t y, coord_t py, logic tk, logic [1:0] md,
                                       logic st, logic qt);
        logic ok;
        ok = (y == py) || (tk && (y == py + 11'd1 || y + 11'd1 == py));
        if (md == MOVE_UP)
            ok = ok && (y <= py);
        if (md == MOVE_DOWN)
            ok = ok && (y >= py);
        if (st && tk && md == MOVE_UP && py > Y_MIN)
            ok = ok && (y + 11'd1 == py);
        if (st && tk && md == MOVE_DOWN && py < Y_MAX)
            ok = ok && (y == py + 11'd1);
        if (qt)
            ok = ok && (y == py);
        return ok && y >= 11'd90 && y <= 11'd410;
    endfunction

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            tick_cnt  <= 0;
            exp_speed <= 3'd1;
            prev_tick <= 1'b0;
            prev_a    <= '0;
            prev_b    <= '0;
            prev_ya   <= Y_RESET_A;
            prev_yb   <= Y_RESET_B;
            model_a   <= 0;
            model_b   <= 0;
        end else begin
            tick_cnt   <= tick ? 0 : tick_cnt + 1;
            exp_speed  <= tick ? speed_t'(sw) + 3'd1 : exp_speed;
            prev_speed <= exp_speed;
            prev_tick  <= tick;
            prev_a     <= shot_a;
            prev_b     <= shot_b;
            prev_ya    <= soldier_a_y;
            prev_yb    <= soldier_b_y;
            if (end_a && end_b && shots_touch(prev_a, prev_b)) begin
                if (prev_a.x >= 11'd320)  // Clash on B's half
                    model_a <= (model_a + 1) % 1000;
                else
                    model_b <= (model_b + 1) % 1000;
            end else begin
                if (end_a && prev_a.x >= X_WALL_B)
                    model_a <= (model_a + 2) % 1000;
                if (end_b && prev_b.x < coord_t'(prev_speed))
                    model_b <= (model_b + 2) % 1000;
            end
        end
    end

    function automatic void report_mismatch(string msg);
        mismatch_cnt++;
        $display("mismatch at %0t: %s", $time, msg);
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------
    a_reset_state: assert property (@(posedge CLK) $fell(RST) |->
        shot_a.phase == SHOT_IDLE && shot_b.phase == SHOT_IDLE && score_a == '0 &&
        score_b == '0 && soldier_a_y == 11'd100 && soldier_b_y == 11'd300)
        else report_mismatch("state right after reset");
    a_rows: assert property (@(posedge CLK) disable iff (RST) $onehot(rows_a) && $onehot(rows_b))
        else report_mismatch("row drive not one-hot");
    a_motion_a: assert property (@(posedge CLK) disable iff (RST)
        motion_ok(soldier_a_y, prev_ya, prev_tick, mode[0], steady[0], quiet[0]))
        else report_mismatch("soldier A step");
    a_motion_b: assert property (@(posedge CLK) disable iff (RST)
        motion_ok(soldier_b_y, prev_yb, prev_tick, mode[1], steady[1], quiet[1]))
        else report_mismatch("soldier B step");
    a_launch_a: assert property (@(posedge CLK) disable iff (RST)
        prev_a.phase == SHOT_IDLE && shot_a.phase == SHOT_FLYING |->
        prev_tick && shot_a.x == 11'd20 && shot_a.y == prev_ya)
        else report_mismatch("shot A launch position");
    a_launch_b: assert property (@(posedge CLK) disable iff (RST)
        prev_b.phase == SHOT_IDLE && shot_b.phase == SHOT_FLYING |->
        prev_tick && shot_b.x == 11'd600 && shot_b.y == prev_yb)
        else report_mismatch("shot B launch position");

    // Nothing in the way, so the shot must keep flying by one step
    a_flight_a: assert property (@(posedge CLK) disable iff (RST)
        prev_tick && prev_a.phase == SHOT_FLYING && prev_a.x < X_WALL_B &&
        !(prev_b.phase == SHOT_FLYING && shots_touch(prev_a, prev_b)) &&
        !hits_soldier(prev_a, X_SOLDIER_B, prev_yb) |->
        shot_a.phase == SHOT_FLYING && shot_a.x == prev_a.x + coord_t'(prev_speed))
        else report_mismatch("shot A flight step");
    a_flight_b: assert property (@(posedge CLK) disable iff (RST)
        prev_tick && prev_b.phase == SHOT_FLYING && prev_b.x >= coord_t'(prev_speed) &&
        !(prev_a.phase == SHOT_FLYING && shots_touch(prev_a, prev_b)) &&
        !hits_soldier(prev_b, X_SOLDIER_A, prev_ya) |->
        shot_b.phase == SHOT_FLYING && shot_b.x + coord_t'(prev_speed) == prev_b.x)
        else report_mismatch("shot B flight step");
    a_wall: assert property (@(posedge CLK) disable iff (RST)
        prev_tick && prev_a.phase == SHOT_FLYING && prev_a.x >= X_WALL_B |->
        shot_a.phase == SHOT_IDLE)
        else report_mismatch("shot A passed the wall");
    a_meet: assert property (@(posedge CLK) disable iff (RST)
        prev_tick && prev_a.phase == SHOT_FLYING && prev_b.phase == SHOT_FLYING &&
        shots_touch(prev_a, prev_b) |-> shot_a.phase == SHOT_IDLE && shot_b.phase == SHOT_IDLE)
        else report_mismatch("shots met but kept flying");
    a_score: assert property (@(posedge CLK) disable iff (RST)
        !prev_tick |-> score_val(score_a) == model_a && score_val(score_b) == model_b)
        else report_mismatch("score differs from model");
    a_digits: assert property (@(posedge CLK) disable iff (RST)
        score_a.hundreds <= 4'd9 && score_a.tens <= 4'd9 && score_a.units <= 4'd9 &&
        score_b.hundreds <= 4'd9 && score_b.tens <= 4'd9 && score_b.units <= 4'd9)
        else report_mismatch("score digit above 9");

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic wait_ticks(int n);
        int k;
        k = 0;
        while (k < n) begin
            @(negedge CLK);
            if (tick)
                k++;
        end
    endtask

    // Holds a move key; stop_near ends it once soldier B reaches A's height
    task automatic hold_key(int p, key_code_t k, int max_ticks, logic stop_near);
        int n;
        @(negedge CLK);
        quiet[p]    = 1'b0;
        held_key[p] = k;
        mode[p]     = (k == KEY_UP) ? MOVE_UP : MOVE_DOWN;
        repeat (2 * SCAN_CYC) @(negedge CLK);  // Surely captured by now
        steady[p] = 1'b1;
        n = 0;
        while (n < max_ticks && !(stop_near && soldier_b_y <= soldier_a_y + 11'd1)) begin
            wait_ticks(1);
            n++;
        end
        @(negedge CLK);
        steady[p]   = 1'b0;
        held_key[p] = '0;
        mode[p]     = MOVE_NONE;
        repeat (3 * SCAN_CYC) @(negedge CLK);  // Held code cleared after one idle scan
        quiet[p] = 1'b1;
    endtask

    task automatic fire_both();
        @(negedge CLK);
        held_key[0] = KEY_FIRE;
        held_key[1] = KEY_FIRE;
        repeat (2 * SCAN_CYC) @(negedge CLK);
        held_key[0] = '0;
        held_key[1] = '0;
    endtask

    task automatic wait_shot(int p, shot_phase_t ph, string what);
        int n;
        n = 0;
        while (((p == 0) ? shot_a.phase : shot_b.phase) != ph && n < FLIGHT_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        if (n >= FLIGHT_LIMIT) begin
            fail_cnt++;
            $display("%0t: shot %0d did not %s in time", $time, p, what);
        end
    endtask

    task automatic shoot_round(string end_what);
        sw = 2'($random(seed));
        fire_both();
        wait_shot(0, SHOT_FLYING, "launch");
        wait_shot(1, SHOT_FLYING, "launch");
        wait_shot(0, SHOT_IDLE, end_what);
        wait_shot(1, SHOT_IDLE, end_what);
    endtask

    initial begin
        seed = 32'hcb840d9d;
        sw   = 2'b00;
        for (int p = 0; p < 2; p++) begin
            held_key[p] = '0;
            mode[p]     = MOVE_NONE;
            steady[p]   = 1'b0;
            quiet[p]    = 1'b0;
        end
        @(negedge RST);
        repeat (2) @(negedge CLK);
        sw = 2'($random(seed));
        hold_key(0, KEY_UP, 5 + ($unsigned($random(seed)) % 16), 1'b0);   // Often hits Y_MIN
        hold_key(1, KEY_DOWN, 5 + ($unsigned($random(seed)) % 16), 1'b0);
        shoot_round("reach the wall");  // Rows far apart
        hold_key(1, KEY_UP, 400, 1'b1);
        shoot_round("meet the other shot");
        repeat (4) @(negedge CLK);
        $display("errors: %0d mismatch, %0d other", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TICKS_NEEDED * GAME_DIV * CLK_PERIOD);
        $display("watchdog expired after %0d game ticks, errors: %0d mismatch, %0d other",
                 TICKS_NEEDED, mismatch_cnt, fail_cnt);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
